// ==== src/conv_pkg.sv ====
// -------------------------------------------------------------------------
// conv1 shared definitions
// widths, kernel geometry and data types for the first convolution layer
// -------------------------------------------------------------------------
package conv_pkg;

  // pixel and coefficient widths
  localparam int data_w   = 8;
  localparam int weight_w = 8;

  // kernel geometry
  localparam int kernel_size  = 5;
  localparam int n_taps       = kernel_size * kernel_size;
  localparam int num_channels = 3;

  // 9-bit zero-extended pixel times signed weight
  localparam int prod_w      = data_w + 1 + weight_w;
  localparam int sum_w       = 22;
  localparam int tree_stages = 5;

  // requantization, Q1.15 scale
  localparam int scale_w  = 16;
  localparam int shift_s  = 15;
  localparam int scaled_w = 40;
  localparam int out_w    = 12;

  typedef logic [data_w-1:0]          pixel_t;
  typedef logic signed [weight_w-1:0] weight_t;
  typedef logic signed [sum_w-1:0]    sum_t;
  typedef logic signed [scale_w-1:0]  scale_t;
  typedef logic signed [out_w-1:0]    conv_out_t;

endpackage

// ==== src/window_gen.sv ====
// -------------------------------------------------------------------------
// window generator
// buffers four image rows and emits each complete 5x5 window
// -------------------------------------------------------------------------
module window_gen #(
  parameter int img_width  = 28,
  parameter int img_height = 28
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  conv_pkg::pixel_t                             pixel,
  input  logic                                         pixel_valid,
  output logic [conv_pkg::n_taps*conv_pkg::data_w-1:0] window,
  output logic                                         window_valid
);

  import conv_pkg::*;

  localparam int n_lines = kernel_size - 1;
  localparam int col_w   = $clog2(img_width);
  localparam int row_w   = $clog2(img_height);

  // line 0 holds the oldest buffered row
  pixel_t line_buf [n_lines][img_width];
  // [row][col], col 0 is the leftmost
  pixel_t shift_q [kernel_size][kernel_size];
  pixel_t cur_col [kernel_size];

  logic [col_w-1:0] col;
  logic [row_w-1:0] row;
  logic             complete;
  logic             win_pend;

  // incoming column, newest pixel at the bottom
  always_comb begin
    for (int r = 0; r < n_lines; r++) begin
      cur_col[r] = line_buf[r][col];
    end
    cur_col[n_lines] = pixel;
  end

  assign complete = pixel_valid && (row >= row_w'(n_lines)) && (col >= col_w'(n_lines));

  // -----------------------------------------------------------------------
  // raster position and valid timing
  // -----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col          <= '0;
      row          <= '0;
      win_pend     <= 1'b0;
      window_valid <= 1'b0;
    end else begin
      win_pend     <= complete;
      window_valid <= win_pend;
      if (pixel_valid) begin
        if (col == col_w'(img_width - 1)) begin
          col <= '0;
          // wrap to the next frame
          if (row == row_w'(img_height - 1)) begin
            row <= '0;
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  // -----------------------------------------------------------------------
  // line buffers and column shift
  // -----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      for (int r = 0; r < n_lines; r++) begin
        line_buf[r][col] <= cur_col[r+1];
      end
      for (int r = 0; r < kernel_size; r++) begin
        for (int c = 0; c < n_lines; c++) begin
          shift_q[r][c] <= shift_q[r][c+1];
        end
        shift_q[r][n_lines] <= cur_col[r];
      end
    end
  end

  // tap r*5+c at bits 8*(r*5+c)
  always_ff @(posedge clk) begin
    if (win_pend) begin
      for (int r = 0; r < kernel_size; r++) begin
        for (int c = 0; c < kernel_size; c++) begin
          window[(r*kernel_size+c)*data_w +: data_w] <= shift_q[r][c];
        end
      end
    end
  end

endmodule

// ==== src/conv_mac_array.sv ====
// -------------------------------------------------------------------------
// MAC array
// window times three kernels, summed per channel in a pipelined adder tree
// -------------------------------------------------------------------------
module conv_mac_array (
  input  logic                                                                clk,
  input  logic                                                                rst_n,
  input  logic [conv_pkg::n_taps*conv_pkg::data_w-1:0]                        window,
  input  logic                                                                window_valid,
  input  logic [conv_pkg::num_channels*conv_pkg::n_taps*conv_pkg::weight_w-1:0] weights,
  output logic [conv_pkg::num_channels*conv_pkg::sum_w-1:0]                   sums,
  output logic                                                                sums_valid
);

  import conv_pkg::*;

  // operands left at the input of a tree level: 25, 13, 7, 4, 2, 1
  function automatic int level_size(int lvl);
    int n;
    n = n_taps;
    for (int s = 0; s < lvl; s++) begin
      n = (n + 1) / 2;
    end
    return n;
  endfunction

  logic signed [data_w:0] px_ext [n_taps];
  logic [tree_stages:0]   vld_sr;

  // pixels are unsigned, one zero bit in front
  for (genvar i = 0; i < n_taps; i++) begin : g_px
    assign px_ext[i] = {1'b0, window[i*data_w +: data_w]};
  end

  // -----------------------------------------------------------------------
  // per channel products and adder tree
  // -----------------------------------------------------------------------
  for (genvar c = 0; c < num_channels; c++) begin : g_ch
    // node[0] holds the products, node[s+1] the outputs of tree level s
    sum_t node [tree_stages+1][n_taps];

    for (genvar i = 0; i < n_taps; i++) begin : g_tap
      weight_t                  w;
      logic signed [prod_w-1:0] prod;

      assign w    = weights[(c*n_taps+i)*weight_w +: weight_w];
      assign prod = px_ext[i] * w;

      // idle cycles feed zeros into the tree
      always_ff @(posedge clk) begin
        if (window_valid) begin
          node[0][i] <= prod;
        end else begin
          node[0][i] <= '0;
        end
      end
    end

    for (genvar s = 0; s < tree_stages; s++) begin : g_lvl
      for (genvar k = 0; k < level_size(s + 1); k++) begin : g_node
        if (2 * k + 1 < level_size(s)) begin : g_add
          always_ff @(posedge clk) begin
            node[s+1][k] <= node[s][2*k] + node[s][2*k+1];
          end
        end else begin : g_pass
          // odd operand moves up a level unchanged
          always_ff @(posedge clk) begin
            node[s+1][k] <= node[s][2*k];
          end
        end
      end
    end

    assign sums[c*sum_w +: sum_w] = node[tree_stages][0];
  end

  // valid follows the data through all six stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[tree_stages-1:0], window_valid};
    end
  end

  assign sums_valid = vld_sr[tree_stages];

endmodule

// ==== src/requant.sv ====
// -------------------------------------------------------------------------
// requantizer
// per-channel Q1.15 scale with round-half-up, bias, 12-bit saturation
// -------------------------------------------------------------------------
module requant (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [conv_pkg::num_channels*conv_pkg::sum_w-1:0]    sums,
  input  logic                                                 sums_valid,
  input  logic [conv_pkg::num_channels*conv_pkg::weight_w-1:0] biases,
  input  logic [conv_pkg::num_channels*conv_pkg::scale_w-1:0]  scales,
  output conv_pkg::conv_out_t                                  conv_out_0,
  output conv_pkg::conv_out_t                                  conv_out_1,
  output conv_pkg::conv_out_t                                  conv_out_2,
  output logic                                                 conv_valid
);

  import conv_pkg::*;

  localparam logic signed [scaled_w-1:0] round_half = 1 <<< (shift_s - 1);
  localparam logic signed [scaled_w-1:0] out_max    = (1 <<< (out_w - 1)) - 1;
  localparam logic signed [scaled_w-1:0] out_min    = -(1 <<< (out_w - 1));

  logic signed [scaled_w-1:0] scaled_c [num_channels];
  logic signed [scaled_w-1:0] scaled_q [num_channels];
  conv_out_t                  bias_q   [num_channels];
  conv_out_t                  result_q [num_channels];
  logic                       stage_vld;

  function automatic conv_out_t saturate(logic signed [scaled_w-1:0] v);
    if (v > out_max) begin
      return conv_out_t'(out_max);
    end
    if (v < out_min) begin
      return conv_out_t'(out_min);
    end
    return conv_out_t'(v);
  endfunction

  // sum * scale + 2^14, then arithmetic shift by 15
  always_comb begin
    sum_t                       ch_sum;
    scale_t                     ch_scale;
    logic signed [scaled_w-1:0] prod;
    for (int c = 0; c < num_channels; c++) begin
      ch_sum      = sums[c*sum_w +: sum_w];
      ch_scale    = scales[c*scale_w +: scale_w];
      prod        = scaled_w'(ch_sum) * scaled_w'(ch_scale);
      scaled_c[c] = (prod + round_half) >>> shift_s;
    end
  end

  // stage 1, scaled value with its bias
  always_ff @(posedge clk) begin
    if (sums_valid) begin
      for (int c = 0; c < num_channels; c++) begin
        scaled_q[c] <= scaled_c[c];
        bias_q[c]   <= weight_t'(biases[c*weight_w +: weight_w]);
      end
    end
  end

  // stage 2, bias add and clip to 12 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_vld  <= 1'b0;
      conv_valid <= 1'b0;
      for (int c = 0; c < num_channels; c++) begin
        result_q[c] <= '0;
      end
    end else begin
      stage_vld  <= sums_valid;
      conv_valid <= stage_vld;
      if (stage_vld) begin
        for (int c = 0; c < num_channels; c++) begin
          result_q[c] <= saturate(scaled_q[c] + bias_q[c]);
        end
      end
    end
  end

  assign conv_out_0 = result_q[0];
  assign conv_out_1 = result_q[1];
  assign conv_out_2 = result_q[2];

endmodule

// ==== src/conv1_layer.sv ====
// -------------------------------------------------------------------------
// conv1 layer top
// 5x5 window generation, three-channel MAC and requantization to 12 bits
// -------------------------------------------------------------------------
module conv1_layer #(
  parameter int img_width  = 28,
  parameter int img_height = 28
) (
  input  logic                                                                clk,
  input  logic                                                                rst_n,
  input  conv_pkg::pixel_t                                                    pixel,
  input  logic                                                                pixel_valid,
  input  logic [conv_pkg::num_channels*conv_pkg::n_taps*conv_pkg::weight_w-1:0] weights,
  input  logic [conv_pkg::num_channels*conv_pkg::weight_w-1:0]                biases,
  input  logic [conv_pkg::num_channels*conv_pkg::scale_w-1:0]                 scales,
  output conv_pkg::conv_out_t                                                 conv_out_0,
  output conv_pkg::conv_out_t                                                 conv_out_1,
  output conv_pkg::conv_out_t                                                 conv_out_2,
  output logic                                                                conv_valid
);

  import conv_pkg::*;

  logic [n_taps*data_w-1:0]      window;
  logic                          window_valid;
  logic [num_channels*sum_w-1:0] sums;
  logic                          sums_valid;

  window_gen #(
    .img_width  (img_width),
    .img_height (img_height)
  ) window_gen_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel        (pixel),
    .pixel_valid  (pixel_valid),
    .window       (window),
    .window_valid (window_valid)
  );

  // 1 product stage + 5 tree stages
  conv_mac_array conv_mac_array_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .window       (window),
    .window_valid (window_valid),
    .weights      (weights),
    .sums         (sums),
    .sums_valid   (sums_valid)
  );

  requant requant_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .sums       (sums),
    .sums_valid (sums_valid),
    .biases     (biases),
    .scales     (scales),
    .conv_out_0 (conv_out_0),
    .conv_out_1 (conv_out_1),
    .conv_out_2 (conv_out_2),
    .conv_valid (conv_valid)
  );

endmodule

// ==== tests/conv1_layer_sva.sv ====
// --------------------------------------------------------------------------
// conv1 layer assertions on valid timing and result hold
// --------------------------------------------------------------------------
module conv1_layer_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                window_valid,
  input logic                conv_valid,
  input conv_pkg::conv_out_t conv_out_0,
  input conv_pkg::conv_out_t conv_out_1,
  input conv_pkg::conv_out_t conv_out_2
);

  // no result while in reset
  assert property (@(posedge clk) !rst_n |-> !conv_valid)
    else $error("conv_valid high during reset");

  // 6 MAC stages plus 2 requant stages
  assert property (@(posedge clk) disable iff (!rst_n) window_valid |-> ##8 conv_valid)
    else $error("conv_valid missing 8 cycles after window_valid");

  // results only move when the output register loads
  assert property (@(posedge clk) disable iff (!rst_n)
    !conv_valid |-> $stable({conv_out_2, conv_out_1, conv_out_0}))
    else $error("conv_out changed without conv_valid");

endmodule

bind conv1_layer conv1_layer_sva conv1_layer_sva_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .window_valid (window_valid),
  .conv_valid   (conv_valid),
  .conv_out_0   (conv_out_0),
  .conv_out_1   (conv_out_1),
  .conv_out_2   (conv_out_2)
);

// ==== tests/conv1_layer_tb.sv ====
// --------------------------------------------------------------------------
// conv1 layer testbench
// 12x10 frames checked against a reference model
// --------------------------------------------------------------------------
module conv1_layer_tb;

  localparam int img_w = 12;
  localparam int img_h = 10;
  localparam int n_px  = img_w * img_h;
  localparam int n_res = (img_w - 4) * (img_h - 4);
  // random, stalled, saturation and two back-to-back frames
  localparam int n_frames  = 5;
  localparam int wd_cycles = n_frames * n_px * 3 + 200;

  logic clk, rst_n, pixel_valid, conv_valid;
  logic [7:0] pixel;
  logic [599:0] weights;
  logic [23:0] biases;
  logic [47:0] scales;
  conv_pkg::conv_out_t conv_out_0, conv_out_1, conv_out_2;

  logic [7:0] frame_mem [2][n_px];
  logic [35:0] exp_q [$];
  time time_q [$];
  int drv_frame, drv_idx, errors, err_base, result_cnt, tests_passed, tests_failed;

  conv1_layer #(.img_width(img_w), .img_height(img_h)) conv1_layer_inst (
    .clk(clk), .rst_n(rst_n), .pixel(pixel), .pixel_valid(pixel_valid),
    .weights(weights), .biases(biases), .scales(scales), .conv_out_0(conv_out_0),
    .conv_out_1(conv_out_1), .conv_out_2(conv_out_2), .conv_valid(conv_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: results did not arrive within %0d cycles", wd_cycles);
    $display("** FAIL **");
    $finish;
  end

  // expected results of one window with channel c at bits 12c
  function automatic logic [35:0] ref_window(int f, int wr, int wc);
    longint acc, v;
    int w, px, sc, b;
    logic [35:0] res;
    for (int ch = 0; ch < 3; ch++) begin
      acc = 0;
      for (int t = 0; t < 25; t++) begin
        w = $signed(weights[(ch * 25 + t) * 8 +: 8]);
        px = frame_mem[f][(wr + t / 5) * img_w + wc + t % 5];
        acc += longint'(px * w);
      end
      sc = $signed(scales[ch * 16 +: 16]);
      b = $signed(biases[ch * 8 +: 8]);
      v = ((acc * sc + 16384) >>> 15) + b;
      if (v > 2047) v = 2047;
      if (v < -2048) v = -2048;
      res[ch * 12 +: 12] = v[11:0];
    end
    return res;
  endfunction

  task automatic check_value(string name, logic [11:0] exp_v, logic [11:0] got);
    if (got !== exp_v) begin
      $display("ERROR %s: expected %h, got %h", name, exp_v, got);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // prediction on accepted pixels and comparison on conv_valid
  // ------------------------------------------------------------------------
  always @(posedge clk) begin : predict
    if (rst_n && pixel_valid && drv_idx / img_w >= 4 && drv_idx % img_w >= 4) begin
      exp_q.push_back(ref_window(drv_frame, drv_idx / img_w - 4, drv_idx % img_w - 4));
      time_q.push_back($time);
    end
  end

  always @(negedge clk) begin : compare
    logic [35:0] exp_v;
    time t_acc;
    if (rst_n && conv_valid) begin
      result_cnt++;
      if (exp_q.size() == 0) begin
        $display("result at time %0t with no completed window", $time);
        errors++;
      end else begin
        exp_v = exp_q.pop_front();
        t_acc = time_q.pop_front();
        check_value("conv_out_0", exp_v[11:0], conv_out_0);
        check_value("conv_out_1", exp_v[23:12], conv_out_1);
        check_value("conv_out_2", exp_v[35:24], conv_out_2);
        // sampled half a cycle after the load
        if (($time - t_acc - 5) / 10 != 9) begin
          $display("result came %0d cycles after its pixel", ($time - t_acc - 5) / 10);
          errors++;
        end
      end
    end
  end

  task automatic random_config();
    int s;
    for (int i = 0; i < 75; i++) begin
      weights[i * 8 +: 8] = 8'($urandom);
    end
    for (int c = 0; c < 3; c++) begin
      biases[c * 8 +: 8] = 8'($urandom);
      s = $urandom_range(2048) - 1024;
      scales[c * 16 +: 16] = s[15:0];
    end
  endtask

  task automatic drive_frame(int f, int gap_pct);
    for (int i = 0; i < n_px; i++) begin
      @(negedge clk);
      while ($urandom_range(99) < gap_pct) begin
        pixel_valid = 1'b0;
        pixel = 8'($urandom);
        @(negedge clk);
      end
      drv_frame = f;
      drv_idx = i;
      pixel = frame_mem[f][i];
      pixel_valid = 1'b1;
    end
  endtask

  task automatic drain_pipeline();
    @(negedge clk);
    pixel_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (12) @(negedge clk);
  endtask

  task automatic end_test(string name, int exp_results);
    if (result_cnt != exp_results) begin
      $display("%s: expected %0d results, got %0d", name, exp_results, result_cnt);
      errors++;
    end
    if (errors == err_base) tests_passed++;
    else tests_failed++;
    $display("test %s: %0d results, %0d errors", name, result_cnt, errors - err_base);
    err_base = errors;
    result_cnt = 0;
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin : run_tests
    {rst_n, pixel_valid, pixel, weights, biases, scales} = '0;
    {drv_frame, drv_idx, errors, err_base, result_cnt, tests_passed, tests_failed} = '0;
    void'($urandom(79));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (10) begin
      check_value("conv_valid", 12'h0, 12'(conv_valid));
      check_value("conv_out_0", 12'h0, conv_out_0);
      check_value("conv_out_1", 12'h0, conv_out_1);
      check_value("conv_out_2", 12'h0, conv_out_2);
      @(negedge clk);
    end
    end_test("reset", 0);

    for (int i = 0; i < n_px; i++) frame_mem[0][i] = 8'($urandom);
    random_config();
    drive_frame(0, 0);
    drain_pipeline();
    end_test("random frame", n_res);

    for (int i = 0; i < n_px; i++) frame_mem[0][i] = 8'($urandom);
    random_config();
    drive_frame(0, 30);
    drain_pipeline();
    end_test("stalled input", n_res);

    // ch0 +127, ch1 -128, ch2 +127 with full-scale pixels
    for (int i = 0; i < n_px; i++) frame_mem[0][i] = 8'hff;
    for (int i = 0; i < 25; i++) begin
      weights[i * 8 +: 8] = 8'h7f;
      weights[(25 + i) * 8 +: 8] = 8'h80;
      weights[(50 + i) * 8 +: 8] = 8'h7f;
    end
    biases = {8'h00, 8'h7f, 8'h80};
    scales = {3{16'h7fff}};
    drive_frame(0, 0);
    drain_pipeline();
    check_value("conv_out_0", 12'h7ff, conv_out_0);
    check_value("conv_out_1", 12'h800, conv_out_1);
    check_value("conv_out_2", 12'h7ff, conv_out_2);
    end_test("saturation", n_res);

    for (int i = 0; i < n_px; i++) begin
      frame_mem[0][i] = 8'($urandom);
      frame_mem[1][i] = 8'($urandom);
    end
    random_config();
    drive_frame(0, 0);
    drive_frame(1, 0);
    drain_pipeline();
    end_test("back-to-back frames", 2 * n_res);

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/conv_pkg.sv
src/window_gen.sv
src/conv_mac_array.sv
src/requant.sv
src/conv1_layer.sv
tests/conv1_layer_sva.sv
tests/conv1_layer_tb.sv
